// ==== include/bus_cfg.svh ====
// 32-bit AXI-lite only; UART_DIV must be 2 or more and the serial port must not be word 0 aliasing
`ifndef BUS_CFG_SVH
`define BUS_CFG_SVH

// bus widths
`define BUS_ADDR_W 32
`define BUS_DATA_W 32

// the only address steered to the transmitter, matched on all bits
`define SERIAL_PORT 32'ha000_03f8

// sram size in words, log2
`define SRAM_DEPTH_LOG2 8

// clocks per serial bit
`define UART_DIV 4

// AXI response code, nothing else is ever returned
`define AXI_RESP_OKAY 2'b00

`endif

// ==== design/bus_pkg.sv ====
// bus types only; widths follow bus_cfg.svh, no burst, id or cache types
`include "bus_cfg.svh"

package bus_pkg;

	// widths that carry a meaning on the bus
	typedef logic [`BUS_ADDR_W-1:0]      addr_t;
	typedef logic [`BUS_DATA_W-1:0]      data_t;
	typedef logic [`BUS_DATA_W/8-1:0]    strb_t;  // one bit per byte lane
	typedef logic [1:0]                  resp_t;
	typedef logic [`SRAM_DEPTH_LOG2-1:0] sram_idx_t;

	// where a write went
	typedef enum logic {
		dest_sram,
		dest_uart
	} xbar_dest_e;

	// 8N1 transmitter
	typedef enum logic [1:0] {
		idle,
		start,
		data,
		stop
	} uart_state_e;

endpackage

// ==== design/axi_lite_if.sv ====
// AXI-lite signals only, no clock inside; master drives valids of aw/w/ar and the b/r readies
`timescale 1ns/1ns

interface axi_lite_if
	import bus_pkg::*;
();

	// write address
	addr_t awaddr;
	logic  awvalid;
	logic  awready;

	// write data
	data_t wdata;
	strb_t wstrb;
	logic  wvalid;
	logic  wready;

	// write response
	resp_t bresp;
	logic  bvalid;
	logic  bready;

	// read address
	addr_t araddr;
	logic  arvalid;
	logic  arready;

	// read data
	data_t rdata;
	resp_t rresp;
	logic  rvalid;
	logic  rready;

	modport master (
		output awaddr, awvalid, input awready,
		output wdata, wstrb, wvalid, input wready,
		input bresp, bvalid, output bready,
		output araddr, arvalid, input arready,
		input rdata, rresp, rvalid, output rready
	);

	modport slave (
		input awaddr, awvalid, output awready,
		input wdata, wstrb, wvalid, output wready,
		output bresp, bvalid, input bready,
		input araddr, arvalid, output arready,
		output rdata, rresp, rvalid, input rready
	);

endinterface

// ==== design/axi_xbar.sv ====
// one write outstanding; master must hold aw and w together; every read goes to the sram
`timescale 1ns/1ns
`include "bus_cfg.svh"

module axi_xbar
	import bus_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n_i,
	axi_lite_if.slave  m_axi,     // from the top level
	axi_lite_if.master sram_axi,
	axi_lite_if.master uart_axi
);

	xbar_dest_e aw_dest;        // live decode
	xbar_dest_e pending_dest;   // route of the write in flight
	logic       pending;
	logic       aw_hs;
	logic       b_hs;

	// exact match only, neighbours fall through to the sram
	assign aw_dest = (m_axi.awaddr == `SERIAL_PORT) ? dest_uart : dest_sram;

	// write payload goes to both, only the valids are steered
	assign sram_axi.awaddr = m_axi.awaddr;
	assign uart_axi.awaddr = m_axi.awaddr;
	assign sram_axi.wdata  = m_axi.wdata;
	assign uart_axi.wdata  = m_axi.wdata;
	assign sram_axi.wstrb  = m_axi.wstrb;
	assign uart_axi.wstrb  = m_axi.wstrb;

	assign sram_axi.awvalid = m_axi.awvalid && !pending && (aw_dest == dest_sram);
	assign uart_axi.awvalid = m_axi.awvalid && !pending && (aw_dest == dest_uart);
	assign sram_axi.wvalid  = m_axi.wvalid && !pending && (aw_dest == dest_sram);
	assign uart_axi.wvalid  = m_axi.wvalid && !pending && (aw_dest == dest_uart);

	// no new address while a response is owed
	assign m_axi.awready = !pending &&
		((aw_dest == dest_uart) ? uart_axi.awready : sram_axi.awready);
	assign m_axi.wready  = !pending &&
		((aw_dest == dest_uart) ? uart_axi.wready : sram_axi.wready);

	// response comes back by the stored route
	assign m_axi.bvalid = pending &&
		((pending_dest == dest_uart) ? uart_axi.bvalid : sram_axi.bvalid);
	assign m_axi.bresp  = (pending_dest == dest_uart) ? uart_axi.bresp : sram_axi.bresp;
	assign sram_axi.bready = m_axi.bready && pending && (pending_dest == dest_sram);
	assign uart_axi.bready = m_axi.bready && pending && (pending_dest == dest_uart);

	// reads pass straight to the sram
	assign sram_axi.araddr  = m_axi.araddr;
	assign sram_axi.arvalid = m_axi.arvalid;
	assign m_axi.arready    = sram_axi.arready;
	assign m_axi.rdata      = sram_axi.rdata;
	assign m_axi.rresp      = sram_axi.rresp;
	assign m_axi.rvalid     = sram_axi.rvalid;
	assign sram_axi.rready  = m_axi.rready;

	// uart has no read side
	assign uart_axi.araddr  = '0;
	assign uart_axi.arvalid = 1'b0;
	assign uart_axi.rready  = 1'b0;

	assign aw_hs = m_axi.awvalid && m_axi.awready;
	assign b_hs  = m_axi.bvalid && m_axi.bready;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pending      <= 1'b0;
			pending_dest <= dest_sram;
		end else if (b_hs) begin
			pending <= 1'b0;
		end else if (aw_hs) begin
			pending      <= 1'b1;
			pending_dest <= aw_dest;  // held until b completes
		end
	end

endmodule

// ==== design/axi_sram.sv ====
// 256 words, address bits above 9 alias; aw and w must arrive together; always answers OKAY
`timescale 1ns/1ns
`include "bus_cfg.svh"

module axi_sram
	import bus_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n_i,
	axi_lite_if.slave s_axi
);

	localparam int DEPTH = 2 ** `SRAM_DEPTH_LOG2;
	localparam int LANES = `BUS_DATA_W / 8;

	data_t     mem [DEPTH];
	sram_idx_t wr_idx;
	sram_idx_t rd_idx;
	logic      wr_hs;
	logic      rd_hs;

	// word index, byte offset dropped
	assign wr_idx = s_axi.awaddr[`SRAM_DEPTH_LOG2+1:2];
	assign rd_idx = s_axi.araddr[`SRAM_DEPTH_LOG2+1:2];

	// aw and w taken in the same cycle, one response at a time
	assign wr_hs         = s_axi.awvalid && s_axi.wvalid && !s_axi.bvalid;
	assign s_axi.awready = wr_hs;
	assign s_axi.wready  = wr_hs;

	assign s_axi.arready = !s_axi.rvalid;
	assign rd_hs         = s_axi.arvalid && s_axi.arready;

	assign s_axi.bresp = `AXI_RESP_OKAY;
	assign s_axi.rresp = `AXI_RESP_OKAY;

	// write response, one cycle after the handshake
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			s_axi.bvalid <= 1'b0;
		end else if (wr_hs) begin
			s_axi.bvalid <= 1'b1;
		end else if (s_axi.bready) begin
			s_axi.bvalid <= 1'b0;
		end
	end

	// read response
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			s_axi.rvalid <= 1'b0;
		end else if (rd_hs) begin
			s_axi.rvalid <= 1'b1;
		end else if (s_axi.rready) begin
			s_axi.rvalid <= 1'b0;  // rdata held until here
		end
	end

	// byte lanes written by strobe
	always_ff @(posedge clk) begin
		if (wr_hs) begin
			for (int i = 0; i < LANES; i++) begin
				if (s_axi.wstrb[i]) begin
					mem[wr_idx][i*8 +: 8] <= s_axi.wdata[i*8 +: 8];
				end
			end
		end
	end

	// whole word out, stays put while rvalid waits
	always_ff @(posedge clk) begin
		if (rd_hs) begin
			s_axi.rdata <= mem[rd_idx];
		end
	end

endmodule

// ==== design/axi_uart_tx.sv ====
// write-only, fixed 8N1 at UART_DIV clocks per bit; only wdata[7:0] is sent, strobes ignored
`timescale 1ns/1ns
`include "bus_cfg.svh"

module axi_uart_tx
	import bus_pkg::*;
(
	input  logic      clk,
	input  logic      arst_n_i,
	axi_lite_if.slave s_axi,
	output logic      uart_tx_o
);

	localparam int DIV_W = $clog2(`UART_DIV);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`UART_DIV - 1);

	uart_state_e      state;
	logic [DIV_W-1:0] div_cnt;   // clocks into the current bit
	logic [2:0]       bit_cnt;   // data bit being sent
	logic [7:0]       shift_q;
	logic             accept;
	logic             bit_end;

	// takes a write only between frames
	assign accept        = s_axi.awvalid && s_axi.wvalid && (state == idle) && !s_axi.bvalid;
	assign s_axi.awready = accept;
	assign s_axi.wready  = accept;
	assign s_axi.bresp   = `AXI_RESP_OKAY;

	// read side unused
	assign s_axi.arready = 1'b0;
	assign s_axi.rvalid  = 1'b0;
	assign s_axi.rdata   = '0;
	assign s_axi.rresp   = `AXI_RESP_OKAY;

	assign bit_end = (div_cnt == DIV_LAST);

	// b answered right away, frame runs on its own
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			s_axi.bvalid <= 1'b0;
		end else if (accept) begin
			s_axi.bvalid <= 1'b1;
		end else if (s_axi.bready) begin
			s_axi.bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state   <= idle;
			div_cnt <= '0;
			bit_cnt <= '0;
		end else if (state == idle) begin
			div_cnt <= '0;
			bit_cnt <= '0;
			if (accept) state <= start;
		end else if (!bit_end) begin
			div_cnt <= div_cnt + 1'b1;
		end else begin
			div_cnt <= '0;
			case (state)
				start: state <= data;
				data: begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == 3'd7) state <= stop;  // last data bit done
				end
				default: state <= idle;  // stop bit done
			endcase
		end
	end

	// lsb goes out first
	always_ff @(posedge clk) begin
		if (accept) begin
			shift_q <= s_axi.wdata[7:0];
		end else if (state == data && bit_end) begin
			shift_q <= shift_q >> 1;
		end
	end

	always_comb begin
		case (state)
			start:   uart_tx_o = 1'b0;
			data:    uart_tx_o = shift_q[0];
			default: uart_tx_o = 1'b1;  // idle and stop are marks
		endcase
	end

endmodule

// ==== design/bus_top.sv ====
// single AXI-lite master port; aw and w must be presented together, one write outstanding
`timescale 1ns/1ns

module bus_top
	import bus_pkg::*;
(
	input  logic  clk,
	input  logic  arst_n_i,
	// write address
	input  addr_t awaddr_i,
	input  logic  awvalid_i,
	output logic  awready_o,
	// write data
	input  data_t wdata_i,
	input  strb_t wstrb_i,
	input  logic  wvalid_i,
	output logic  wready_o,
	// write response
	output resp_t bresp_o,
	output logic  bvalid_o,
	input  logic  bready_i,
	// read address
	input  addr_t araddr_i,
	input  logic  arvalid_i,
	output logic  arready_o,
	// read data
	output data_t rdata_o,
	output resp_t rresp_o,
	output logic  rvalid_o,
	input  logic  rready_i,
	// serial line
	output logic  uart_tx_o
);

	axi_lite_if m_if ();
	axi_lite_if sram_if ();
	axi_lite_if uart_if ();

	// master side of the crossbar
	assign m_if.awaddr  = awaddr_i;
	assign m_if.awvalid = awvalid_i;
	assign awready_o    = m_if.awready;
	assign m_if.wdata   = wdata_i;
	assign m_if.wstrb   = wstrb_i;
	assign m_if.wvalid  = wvalid_i;
	assign wready_o     = m_if.wready;
	assign bresp_o      = m_if.bresp;
	assign bvalid_o     = m_if.bvalid;
	assign m_if.bready  = bready_i;
	assign m_if.araddr  = araddr_i;
	assign m_if.arvalid = arvalid_i;
	assign arready_o    = m_if.arready;
	assign rdata_o      = m_if.rdata;
	assign rresp_o      = m_if.rresp;
	assign rvalid_o     = m_if.rvalid;
	assign m_if.rready  = rready_i;

	axi_xbar i_xbar (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.m_axi    (m_if.slave),
		.sram_axi (sram_if.master),
		.uart_axi (uart_if.master)
	);

	axi_sram i_sram (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.s_axi    (sram_if.slave)
	);

	axi_uart_tx i_uart_tx (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.s_axi     (uart_if.slave),
		.uart_tx_o (uart_tx_o)
	);

endmodule

// ==== tests/bus_checker.sv ====
// samples at the rising edge; expects every response OKAY, UART_DIV at least 2
`timescale 1ns/1ns
`include "bus_cfg.svh"

module bus_checker
	import bus_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n_i,
	input  logic       awready_i,
	input  logic       wready_i,
	input  logic       arready_i,
	input  logic       bvalid_i,
	input  logic       bready_i,
	input  resp_t      bresp_i,
	input  logic       rvalid_i,
	input  logic       rready_i,
	input  data_t      rdata_i,
	input  resp_t      rresp_i,
	input  logic       uart_tx_i,
	input  data_t      exp_rdata_i,
	input  logic       exp_push_i,
	input  logic [7:0] exp_byte_i,
	output int         err_cnt_o,
	output int         check_cnt_o,
	output int         frames_o
);

	localparam resp_t OKAY = 2'b00;

	logic [7:0] exp_q [$];  // bytes owed on the serial line
	logic       b_held;
	logic       r_held;
	resp_t      bresp_q;
	data_t      rdata_q;

	initial begin
		err_cnt_o   = 0;
		check_cnt_o = 0;
		frames_o    = 0;
	end

	task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] got);
		err_cnt_o++;
		$display("** Error at %0t ns: %s expected %h got %h", $time, name, exp, got);
	endtask

	task automatic other_error(input string msg);
		err_cnt_o++;
		$display("error at %0t ns: %s", $time, msg);
	endtask

	// responses, and what a stalled response must keep
	always @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			b_held <= 1'b0;
			r_held <= 1'b0;
		end else begin
			// aw and w are taken together, and never with a response owed
			if (awready_i !== wready_i) begin
				other_error("awready_o and wready_o differ");
			end
			if (bvalid_i && awready_i) begin
				other_error("awready_o high while a write response is pending");
			end
			if (arready_i !== !rvalid_i) begin
				other_error("arready_o does not follow the pending read response");
			end
			if (b_held && !bvalid_i) begin
				other_error("bvalid_o dropped while bready_i was low");
			end else if (b_held && bresp_i !== bresp_q) begin
				value_error("bresp_o", bresp_q, bresp_i);
			end
			if (bvalid_i && bready_i) begin
				check_cnt_o++;
				if (bresp_i !== OKAY) value_error("bresp_o", OKAY, bresp_i);
			end
			if (r_held && !rvalid_i) begin
				other_error("rvalid_o dropped while rready_i was low");
			end else if (r_held && rdata_i !== rdata_q) begin
				value_error("rdata_o", rdata_q, rdata_i);  // changed during the stall
			end
			if (rvalid_i && rready_i) begin
				check_cnt_o++;
				if (rdata_i !== exp_rdata_i) value_error("rdata_o", exp_rdata_i, rdata_i);
				if (rresp_i !== OKAY) value_error("rresp_o", OKAY, rresp_i);
			end
			b_held  <= bvalid_i && !bready_i;
			r_held  <= rvalid_i && !rready_i;
			bresp_q <= bresp_i;
			rdata_q <= rdata_i;
		end
	end

	always @(posedge clk) begin
		if (exp_push_i) exp_q.push_back(exp_byte_i);
	end

	// 8N1 receiver, samples each bit in its middle
	always begin : rx_frame
		logic [7:0] rx_byte;
		logic [7:0] want;
		@(posedge clk);
		if (arst_n_i && !uart_tx_i) begin
			repeat (`UART_DIV / 2) @(posedge clk);
			if (uart_tx_i) other_error("start bit on uart_tx_o ended early");
			for (int i = 0; i < 8; i++) begin
				repeat (`UART_DIV) @(posedge clk);
				rx_byte[i] = uart_tx_i;  // lsb first
			end
			repeat (`UART_DIV) @(posedge clk);
			if (!uart_tx_i) other_error("stop bit on uart_tx_o is low");
			frames_o++;
			check_cnt_o++;
			if (exp_q.size() == 0) begin
				other_error($sformatf("frame %h on uart_tx_o with no write to the port", rx_byte));
			end else begin
				want = exp_q.pop_front();
				if (want !== rx_byte) value_error("uart_tx_o byte", want, rx_byte);
				else $display("frame %h seen on uart_tx_o", rx_byte);
			end
		end
	end

endmodule

// ==== tests/bus_tb.sv ====
// single master, aw and w always presented together; frame checks assume UART_DIV is even
`timescale 1ns/1ns
`include "bus_cfg.svh"

module bus_tb
	import bus_pkg::*;
();

	localparam int NUM_TESTS    = 12;
	localparam int FRAME_CYCLES = 10 * `UART_DIV;  // start, 8 data, stop

	typedef struct packed {
		logic       is_read;
		addr_t      addr;
		data_t      data;
		strb_t      strb;
		data_t      exp;
		logic [1:0] stall;  // cycles with bready or rready held low
	} test_t;

	logic       clk;
	logic       arst_n;
	addr_t      awaddr;
	logic       awvalid;
	logic       awready;
	data_t      wdata;
	strb_t      wstrb;
	logic       wvalid;
	logic       wready;
	resp_t      bresp;
	logic       bvalid;
	logic       bready;
	addr_t      araddr;
	logic       arvalid;
	logic       arready;
	data_t      rdata;
	resp_t      rresp;
	logic       rvalid;
	logic       rready;
	logic       uart_tx;
	logic       exp_push;
	logic [7:0] exp_byte;
	data_t      exp_rdata;
	int         err_cnt;
	int         check_cnt;
	int         frames;
	int         n_frames;
	test_t      tbl [NUM_TESTS];

	always #10 clk = ~clk;

	bus_top i_bus_top (
		.clk       (clk),
		.arst_n_i  (arst_n),
		.awaddr_i  (awaddr),
		.awvalid_i (awvalid),
		.awready_o (awready),
		.wdata_i   (wdata),
		.wstrb_i   (wstrb),
		.wvalid_i  (wvalid),
		.wready_o  (wready),
		.bresp_o   (bresp),
		.bvalid_o  (bvalid),
		.bready_i  (bready),
		.araddr_i  (araddr),
		.arvalid_i (arvalid),
		.arready_o (arready),
		.rdata_o   (rdata),
		.rresp_o   (rresp),
		.rvalid_o  (rvalid),
		.rready_i  (rready),
		.uart_tx_o (uart_tx)
	);

	bus_checker i_bus_checker (
		.clk         (clk),
		.arst_n_i    (arst_n),
		.awready_i   (awready),
		.wready_i    (wready),
		.arready_i   (arready),
		.bvalid_i    (bvalid),
		.bready_i    (bready),
		.bresp_i     (bresp),
		.rvalid_i    (rvalid),
		.rready_i    (rready),
		.rdata_i     (rdata),
		.rresp_i     (rresp),
		.uart_tx_i   (uart_tx),
		.exp_rdata_i (exp_rdata),
		.exp_push_i  (exp_push),
		.exp_byte_i  (exp_byte),
		.err_cnt_o   (err_cnt),
		.check_cnt_o (check_cnt),
		.frames_o    (frames)
	);

	// old word with the strobed byte lanes taken from the new one
	function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input strb_t strb);
		data_t res;
		res = old_w;
		for (int i = 0; i < 4; i++) begin
			if (strb[i]) res[i*8 +: 8] = new_w[i*8 +: 8];
		end
		return res;
	endfunction

	function automatic test_t write_entry(input addr_t a, input data_t d, input strb_t s);
		test_t t;
		t      = '0;
		t.addr = a;
		t.data = d;
		t.strb = s;
		return t;
	endfunction

	function automatic test_t read_entry(input addr_t a, input data_t e);
		test_t t;
		t         = '0;
		t.is_read = 1'b1;
		t.addr    = a;
		t.exp     = e;
		return t;
	endfunction

	// starts right after a clock edge, returns on the b handshake edge
	task automatic do_write(input test_t t);
		awaddr   <= t.addr;
		awvalid  <= 1'b1;
		wdata    <= t.data;
		wstrb    <= t.strb;
		wvalid   <= 1'b1;
		exp_push <= (t.addr == `SERIAL_PORT);  // exact match means a frame is due
		exp_byte <= t.data[7:0];
		do begin
			@(posedge clk);
			exp_push <= 1'b0;
		end while (!(awready && wready));
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		repeat (t.stall) @(posedge clk);
		bready <= 1'b1;
		do @(posedge clk); while (!bvalid);
		bready <= 1'b0;
	endtask

	task automatic do_read(input test_t t);
		araddr    <= t.addr;
		arvalid   <= 1'b1;
		exp_rdata <= t.exp;
		do @(posedge clk); while (!arready);
		arvalid <= 1'b0;
		repeat (t.stall) @(posedge clk);
		rready <= 1'b1;
		do @(posedge clk); while (!rvalid);
		rready <= 1'b0;
	endtask

	initial begin
		data_t part_word;
		int    err_before;
		void'($urandom(32'h861f));
		part_word = merge_bytes(32'h1234_5678, 32'haabb_ccdd, 4'b0101);
		tbl[0]  = write_entry(32'h0000_0010, 32'h1234_5678, 4'hf);
		tbl[1]  = read_entry(32'h0000_0010, 32'h1234_5678);
		tbl[2]  = write_entry(32'h0000_0010, 32'haabb_ccdd, 4'b0101);
		tbl[3]  = read_entry(32'h0000_0010, part_word);
		tbl[4]  = write_entry(32'h0000_03f8, 32'h1111_2222, 4'hf);  // same sram word as the port
		tbl[5]  = write_entry(`SERIAL_PORT, 32'h0000_0055, 4'hf);
		tbl[6]  = read_entry(32'h0000_03f8, 32'h1111_2222);
		tbl[7]  = write_entry(`SERIAL_PORT, 32'h0000_00a3, 4'hf);
		tbl[8]  = write_entry(`SERIAL_PORT, 32'hffff_ff3c, 4'hf);  // stalls behind the frame
		tbl[9]  = write_entry(`SERIAL_PORT + 4, 32'hcafe_f00d, 4'hf);
		tbl[10] = read_entry(32'h0000_03fc, 32'hcafe_f00d);       // upper bits alias
		tbl[11] = read_entry(32'h0000_0010, part_word);
		for (int i = 0; i < NUM_TESTS; i++) begin
			tbl[i].stall = 2'($urandom % 4);
		end

		clk       = 1'b0;
		arst_n    = 1'b0;
		awaddr    = '0;
		awvalid   = 1'b0;
		wdata     = '0;
		wstrb     = '0;
		wvalid    = 1'b0;
		bready    = 1'b0;
		araddr    = '0;
		arvalid   = 1'b0;
		rready    = 1'b0;
		exp_push  = 1'b0;
		exp_byte  = '0;
		exp_rdata = '0;
		n_frames  = 0;
		repeat (8) @(posedge clk);
		arst_n <= 1'b1;
		@(posedge clk);

		for (int i = 0; i < NUM_TESTS; i++) begin
			err_before = err_cnt;
			if (tbl[i].is_read) begin
				do_read(tbl[i]);
			end else begin
				if (tbl[i].addr == `SERIAL_PORT) n_frames++;
				do_write(tbl[i]);
			end
			$display("test %0d %s addr %h stall %0d: %s", i, tbl[i].is_read ? "read " : "write",
				tbl[i].addr, tbl[i].stall, (err_cnt == err_before) ? "ok" : "mismatch");
		end

		// let the last frames finish, then leave room for a stray one
		while (frames < n_frames) @(posedge clk);
		repeat (FRAME_CYCLES + 4) @(posedge clk);
		$display("tests %0d, checks %0d, frames %0d of %0d, errors %0d",
			NUM_TESTS, check_cnt, frames, n_frames, err_cnt);
		if (err_cnt == 0 && frames == n_frames) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

	// budget per entry covers one full frame plus the bus handshakes
	initial begin
		repeat (8 + NUM_TESTS * (FRAME_CYCLES + 20)) @(posedge clk);
		$display("timeout at %0t ns, the bus or the serial line stopped making progress", $time);
		$display("Testbench failed");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+include
design/bus_pkg.sv
design/axi_lite_if.sv
design/axi_xbar.sv
design/axi_sram.sv
design/axi_uart_tx.sv
design/bus_top.sv
tests/bus_checker.sv
tests/bus_tb.sv
